// ==== hw/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

	// ============================================================
	// widths that carry a meaning
	// ============================================================

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [3:0] op_kind_t;
	typedef logic [2:0] dp_class_t;
	typedef logic [2:0] fwd_sel_t;
	typedef logic [1:0] t_time_t;
	typedef logic [1:0] alu_op_t;
	typedef logic [1:0] ext_mode_t;
	typedef logic [1:0] jump_mode_t;
	typedef logic [1:0] wb_sel_t;

	localparam reg_addr_t REG_ZERO = 5'd0;
	localparam reg_addr_t REG_RA = 5'd31;

	// opcode and funct fields of the supported subset.
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_J = 6'h02;
	localparam logic [5:0] OP_JAL = 6'h03;
	localparam logic [5:0] OP_BEQ = 6'h04;
	localparam logic [5:0] OP_ORI = 6'h0d;
	localparam logic [5:0] OP_LUI = 6'h0f;
	localparam logic [5:0] OP_LW = 6'h23;
	localparam logic [5:0] OP_SW = 6'h2b;
	localparam logic [5:0] FN_JR = 6'h08;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;

	// ============================================================
	// instruction kinds and datapath classes
	// ============================================================

	localparam op_kind_t KIND_ADDU = 4'd0;
	localparam op_kind_t KIND_SUBU = 4'd1;
	localparam op_kind_t KIND_ORI = 4'd2;
	localparam op_kind_t KIND_LUI = 4'd3;
	localparam op_kind_t KIND_LW = 4'd4;
	localparam op_kind_t KIND_SW = 4'd5;
	localparam op_kind_t KIND_BEQ = 4'd6;
	localparam op_kind_t KIND_J = 4'd7;
	localparam op_kind_t KIND_JAL = 4'd8;
	localparam op_kind_t KIND_JR = 4'd9;
	localparam op_kind_t KIND_NOP = 4'd10;
	localparam op_kind_t KIND_UNKNOWN = 4'd15;

	localparam dp_class_t CLS_CAL_R = 3'd0;
	localparam dp_class_t CLS_CAL_I = 3'd1;
	localparam dp_class_t CLS_LOAD = 3'd2;
	localparam dp_class_t CLS_STORE = 3'd3;
	localparam dp_class_t CLS_BRANCH = 3'd4;
	localparam dp_class_t CLS_JUMP_I = 3'd5;
	localparam dp_class_t CLS_JUMP_R = 3'd6;
	localparam dp_class_t CLS_NOP = 3'd7;

	// forwarding sources, searched newest first.
	localparam fwd_sel_t FWD_ORIG = 3'd0;
	localparam fwd_sel_t FWD_E_PC8 = 3'd1;
	localparam fwd_sel_t FWD_M_PC8 = 3'd2;
	localparam fwd_sel_t FWD_M_ALU = 3'd3;
	localparam fwd_sel_t FWD_W_RF = 3'd4;

	localparam t_time_t T_NEVER = 2'd3;

	localparam alu_op_t ALU_ADD = 2'd0;
	localparam alu_op_t ALU_SUB = 2'd1;
	localparam alu_op_t ALU_OR = 2'd2;

	localparam ext_mode_t EXT_ZERO = 2'd0;
	localparam ext_mode_t EXT_SIGN = 2'd1;
	localparam ext_mode_t EXT_UPPER = 2'd2;

	localparam jump_mode_t NPC_SEQ = 2'd0;
	localparam jump_mode_t NPC_BEQ = 2'd1;
	localparam jump_mode_t NPC_J = 2'd2;
	localparam jump_mode_t NPC_REG = 2'd3;

	localparam wb_sel_t WB_ALU = 2'd0;
	localparam wb_sel_t WB_MEM = 2'd1;
	localparam wb_sel_t WB_PC8 = 2'd2;

	// ============================================================
	// structs passed between blocks
	// ============================================================

	// cls holds the datapath class.
	typedef struct packed {
		op_kind_t kind;
		dp_class_t cls;
		logic rs_used;
		logic rt_used;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t dest;
	} decode_t;

	typedef struct packed {
		jump_mode_t jump_mode;
		ext_mode_t ext_mode;
		alu_op_t alu_op;
		logic alu_src;
		logic dm_we;
		logic rf_we;
		wb_sel_t wb_sel;
	} ctrl_word_t;

	typedef struct packed {
		fwd_sel_t d1;
		fwd_sel_t d2;
		fwd_sel_t e1;
		fwd_sel_t e2;
		fwd_sel_t m;
	} fwd_t;

	typedef struct packed {
		logic en;
		reg_addr_t addr;
		word_t data;
	} retire_t;

	typedef struct packed {
		logic en;
		word_t addr;
		word_t data;
	} store_t;

endpackage

`default_nettype wire

// ==== hw/instr_decode.sv ====
`default_nettype none

module instr_decode (
	input  mips_pkg::word_t   instr,
	output mips_pkg::decode_t dec
);

	logic [5:0] op;
	logic [5:0] funct;
	logic [4:0] shamt;
	logic special;
	mips_pkg::reg_addr_t rs;
	mips_pkg::reg_addr_t rt;
	mips_pkg::reg_addr_t rd;
	mips_pkg::op_kind_t kind;
	mips_pkg::dp_class_t cls;

	assign op = instr[31:26];
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];
	assign shamt = instr[10:6];
	assign funct = instr[5:0];
	assign special = (op == mips_pkg::OP_SPECIAL) && (shamt == 5'd0);

	// the all-zero word is sll $0, so it is matched first as a nop.
	assign kind =
		(instr == '0) ? mips_pkg::KIND_NOP :
		(special && funct == mips_pkg::FN_ADDU) ? mips_pkg::KIND_ADDU :
		(special && funct == mips_pkg::FN_SUBU) ? mips_pkg::KIND_SUBU :
		(special && funct == mips_pkg::FN_JR && rt == 5'd0 && rd == 5'd0) ? mips_pkg::KIND_JR :
		(op == mips_pkg::OP_LUI && rs == 5'd0) ? mips_pkg::KIND_LUI :
		(op == mips_pkg::OP_ORI) ? mips_pkg::KIND_ORI :
		(op == mips_pkg::OP_LW) ? mips_pkg::KIND_LW :
		(op == mips_pkg::OP_SW) ? mips_pkg::KIND_SW :
		(op == mips_pkg::OP_BEQ) ? mips_pkg::KIND_BEQ :
		(op == mips_pkg::OP_J) ? mips_pkg::KIND_J :
		(op == mips_pkg::OP_JAL) ? mips_pkg::KIND_JAL :
		mips_pkg::KIND_UNKNOWN;

	assign cls =
		(kind == mips_pkg::KIND_ADDU || kind == mips_pkg::KIND_SUBU) ? mips_pkg::CLS_CAL_R :
		(kind == mips_pkg::KIND_ORI || kind == mips_pkg::KIND_LUI) ? mips_pkg::CLS_CAL_I :
		(kind == mips_pkg::KIND_LW) ? mips_pkg::CLS_LOAD :
		(kind == mips_pkg::KIND_SW) ? mips_pkg::CLS_STORE :
		(kind == mips_pkg::KIND_BEQ) ? mips_pkg::CLS_BRANCH :
		(kind == mips_pkg::KIND_J || kind == mips_pkg::KIND_JAL) ? mips_pkg::CLS_JUMP_I :
		(kind == mips_pkg::KIND_JR) ? mips_pkg::CLS_JUMP_R :
		mips_pkg::CLS_NOP;

	assign dec.kind = kind;
	assign dec.cls = cls;
	assign dec.rs_used = (cls != mips_pkg::CLS_JUMP_I) && (cls != mips_pkg::CLS_NOP);
	assign dec.rt_used = (cls == mips_pkg::CLS_CAL_R) || (cls == mips_pkg::CLS_STORE) ||
		(cls == mips_pkg::CLS_BRANCH);
	assign dec.rs = dec.rs_used ? rs : mips_pkg::REG_ZERO;
	assign dec.rt = dec.rt_used ? rt : mips_pkg::REG_ZERO;

	// i-type results land in rt, jal links through ra.
	assign dec.dest =
		(cls == mips_pkg::CLS_CAL_R) ? rd :
		(cls == mips_pkg::CLS_CAL_I || cls == mips_pkg::CLS_LOAD) ? rt :
		(kind == mips_pkg::KIND_JAL) ? mips_pkg::REG_RA :
		mips_pkg::REG_ZERO;

endmodule

`default_nettype wire

// ==== hw/hazard_control.sv ====
`default_nettype none

module hazard_control (
	input  logic                 clk,
	input  logic                 rst,
	input  mips_pkg::decode_t    dec_d,
	input  mips_pkg::decode_t    dec_e,
	input  mips_pkg::decode_t    dec_m,
	input  mips_pkg::decode_t    dec_w,
	output mips_pkg::ctrl_word_t ctrl_d,
	output mips_pkg::ctrl_word_t ctrl_e,
	output mips_pkg::ctrl_word_t ctrl_m,
	output mips_pkg::ctrl_word_t ctrl_w,
	output mips_pkg::fwd_t       fwd,
	output logic                 stall
);

	logic bubble_e;
	logic stall_rs;
	logic stall_rt;
	mips_pkg::t_time_t use_rs;
	mips_pkg::t_time_t use_rt;
	mips_pkg::t_time_t new_e;
	mips_pkg::t_time_t new_m;

	// ============================================================
	// control words
	// ============================================================

	function automatic mips_pkg::ctrl_word_t ctrl_of(input mips_pkg::decode_t dec);
		mips_pkg::ctrl_word_t cw;
		cw.jump_mode = (dec.cls == mips_pkg::CLS_BRANCH) ? mips_pkg::NPC_BEQ :
			(dec.cls == mips_pkg::CLS_JUMP_I) ? mips_pkg::NPC_J :
			(dec.cls == mips_pkg::CLS_JUMP_R) ? mips_pkg::NPC_REG :
			mips_pkg::NPC_SEQ;
		cw.ext_mode = (dec.kind == mips_pkg::KIND_LUI) ? mips_pkg::EXT_UPPER :
			(dec.kind == mips_pkg::KIND_ORI) ? mips_pkg::EXT_ZERO :
			mips_pkg::EXT_SIGN;
		// lui comes out of the or with rs fixed at zero.
		cw.alu_op = (dec.kind == mips_pkg::KIND_SUBU) ? mips_pkg::ALU_SUB :
			(dec.cls == mips_pkg::CLS_CAL_I) ? mips_pkg::ALU_OR :
			mips_pkg::ALU_ADD;
		cw.alu_src = (dec.cls == mips_pkg::CLS_CAL_I) || (dec.cls == mips_pkg::CLS_LOAD) ||
			(dec.cls == mips_pkg::CLS_STORE);
		cw.dm_we = (dec.cls == mips_pkg::CLS_STORE);
		cw.rf_we = (dec.dest != mips_pkg::REG_ZERO);
		cw.wb_sel = (dec.cls == mips_pkg::CLS_LOAD) ? mips_pkg::WB_MEM :
			(dec.kind == mips_pkg::KIND_JAL) ? mips_pkg::WB_PC8 :
			mips_pkg::WB_ALU;
		return cw;
	endfunction

	// E holds an inserted nop the cycle after a stall.
	always_ff @(posedge clk) begin
		if (rst) begin
			bubble_e <= 1'b0;
		end else begin
			bubble_e <= stall;
		end
	end

	assign ctrl_d = ctrl_of(dec_d);
	assign ctrl_e = bubble_e ? '0 : ctrl_of(dec_e);
	assign ctrl_m = ctrl_of(dec_m);
	assign ctrl_w = ctrl_of(dec_w);

	// ============================================================
	// forwarding
	// ============================================================

	function automatic logic hit(input mips_pkg::reg_addr_t src, input mips_pkg::decode_t prod);
		return (src != mips_pkg::REG_ZERO) && (src == prod.dest);
	endfunction

	// a producer that cannot deliver yet leaves FWD_ORIG, the stall covers it.
	function automatic mips_pkg::fwd_sel_t pick(input mips_pkg::reg_addr_t src,
			input logic from_e, input logic from_m);
		if (from_e && hit(src, dec_e)) begin
			return (dec_e.kind == mips_pkg::KIND_JAL) ? mips_pkg::FWD_E_PC8 : mips_pkg::FWD_ORIG;
		end
		if (from_m && hit(src, dec_m)) begin
			if (dec_m.kind == mips_pkg::KIND_JAL) begin
				return mips_pkg::FWD_M_PC8;
			end
			return (dec_m.cls == mips_pkg::CLS_LOAD) ? mips_pkg::FWD_ORIG : mips_pkg::FWD_M_ALU;
		end
		return hit(src, dec_w) ? mips_pkg::FWD_W_RF : mips_pkg::FWD_ORIG;
	endfunction

	always_comb begin
		fwd.d1 = pick(dec_d.rs, 1'b1, 1'b1);
		fwd.d2 = pick(dec_d.rt, 1'b1, 1'b1);
		fwd.e1 = pick(dec_e.rs, 1'b0, 1'b1);
		fwd.e2 = pick(dec_e.rt, 1'b0, 1'b1);
		fwd.m = pick(dec_m.rt, 1'b0, 1'b0);
	end

	// ============================================================
	// stall
	// ============================================================

	// cycles until the decode instruction needs each source.
	assign use_rs = !dec_d.rs_used ? mips_pkg::T_NEVER :
		(dec_d.cls == mips_pkg::CLS_BRANCH || dec_d.cls == mips_pkg::CLS_JUMP_R) ? 2'd0 :
		2'd1;
	assign use_rt = !dec_d.rt_used ? mips_pkg::T_NEVER :
		(dec_d.cls == mips_pkg::CLS_STORE) ? 2'd2 :
		(dec_d.cls == mips_pkg::CLS_BRANCH) ? 2'd0 :
		2'd1;

	// cycles until a producer's result can be forwarded.
	assign new_e = (dec_e.cls == mips_pkg::CLS_LOAD) ? 2'd2 :
		(dec_e.cls == mips_pkg::CLS_CAL_R || dec_e.cls == mips_pkg::CLS_CAL_I) ? 2'd1 :
		2'd0;
	assign new_m = (dec_m.cls == mips_pkg::CLS_LOAD) ? 2'd1 : 2'd0;

	function automatic logic too_early(input mips_pkg::reg_addr_t src,
			input mips_pkg::t_time_t t_use);
		if (hit(src, dec_e)) begin
			return t_use < new_e;
		end
		return hit(src, dec_m) && (t_use < new_m);
	endfunction

	always_comb begin
		stall_rs = too_early(dec_d.rs, use_rs);
		stall_rt = too_early(dec_d.rt, use_rt);
	end

	assign stall = stall_rs || stall_rt;

endmodule

`default_nettype wire

// ==== hw/reg_file.sv ====
`default_nettype none

module reg_file (
	input  logic                clk,
	input  logic                rst,
	input  mips_pkg::reg_addr_t ra1,
	input  mips_pkg::reg_addr_t ra2,
	output mips_pkg::word_t     rd1,
	output mips_pkg::word_t     rd2,
	input  logic                we,
	input  mips_pkg::reg_addr_t wa,
	input  mips_pkg::word_t     wd
);

	mips_pkg::word_t regs [1:31];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wa != mips_pkg::REG_ZERO) begin
			regs[wa] <= wd;
		end
	end

	// a write in this cycle is visible to the decode read.
	assign rd1 = (ra1 == mips_pkg::REG_ZERO) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
	assign rd2 = (ra2 == mips_pkg::REG_ZERO) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

endmodule

`default_nettype wire

// ==== hw/datapath.sv ====
`default_nettype none

module datapath #(
	parameter int IMEM_DEPTH = 256,
	parameter int DMEM_DEPTH = 256
) (
	input  logic                          clk,
	input  logic                          rst,
	output logic [$clog2(IMEM_DEPTH)-1:0] imem_addr,
	input  mips_pkg::word_t               imem_data,
	output mips_pkg::word_t               instr_d,
	output mips_pkg::word_t               instr_e,
	output mips_pkg::word_t               instr_m,
	output mips_pkg::word_t               instr_w,
	input  mips_pkg::ctrl_word_t          ctrl_d,
	input  mips_pkg::ctrl_word_t          ctrl_e,
	input  mips_pkg::ctrl_word_t          ctrl_m,
	input  mips_pkg::ctrl_word_t          ctrl_w,
	input  mips_pkg::fwd_t                fwd,
	input  logic                          stall,
	output mips_pkg::reg_addr_t           rf_ra1,
	output mips_pkg::reg_addr_t           rf_ra2,
	input  mips_pkg::word_t               rf_rd1,
	input  mips_pkg::word_t               rf_rd2,
	output logic                          rf_we,
	output mips_pkg::reg_addr_t           rf_wa,
	output mips_pkg::word_t               rf_wd,
	output logic [$clog2(DMEM_DEPTH)-1:0] dm_addr,
	output mips_pkg::word_t               dm_wdata,
	output logic                          dm_we,
	input  mips_pkg::word_t               dm_rdata,
	output mips_pkg::retire_t             retire,
	output mips_pkg::store_t              store
);

	localparam int IA = $clog2(IMEM_DEPTH);
	localparam int DA = $clog2(DMEM_DEPTH);

	mips_pkg::word_t pc;
	mips_pkg::word_t npc;
	mips_pkg::word_t pc8_d, pc8_e, pc8_m, pc8_w;
	mips_pkg::word_t imm_d, imm_e;
	mips_pkg::word_t d1_val, d2_val;
	mips_pkg::word_t rs_val_e, rt_val_e;
	mips_pkg::word_t alu_a, alu_b, rt_fwd_e, alu_y;
	mips_pkg::word_t alu_m, rt_val_m, st_data;
	mips_pkg::word_t alu_w, mem_w, wb_data;

	function automatic mips_pkg::word_t pick(input mips_pkg::fwd_sel_t sel,
			input mips_pkg::word_t orig);
		case (sel)
			mips_pkg::FWD_E_PC8: return pc8_e;
			mips_pkg::FWD_M_PC8: return pc8_m;
			mips_pkg::FWD_M_ALU: return alu_m;
			mips_pkg::FWD_W_RF: return wb_data;
			default: return orig;
		endcase
	endfunction

	// ============================================================
	// fetch and decode
	// ============================================================

	assign imem_addr = pc[IA+1:2];
	assign rf_ra1 = instr_d[25:21];
	assign rf_ra2 = instr_d[20:16];

	always_comb begin
		case (ctrl_d.ext_mode)
			mips_pkg::EXT_ZERO: imm_d = {16'b0, instr_d[15:0]};
			mips_pkg::EXT_UPPER: imm_d = {instr_d[15:0], 16'b0};
			default: imm_d = {{16{instr_d[15]}}, instr_d[15:0]};
		endcase
		d1_val = pick(fwd.d1, rf_rd1);
		d2_val = pick(fwd.d2, rf_rd2);
	end

	// pc already points at the delay slot, so targets are relative to it.
	always_comb begin
		case (ctrl_d.jump_mode)
			mips_pkg::NPC_BEQ: npc = (d1_val == d2_val) ? pc + {imm_d[29:0], 2'b00} : pc + 32'd4;
			mips_pkg::NPC_J: npc = {pc[31:28], instr_d[25:0], 2'b00};
			mips_pkg::NPC_REG: npc = d1_val;
			default: npc = pc + 32'd4;
		endcase
	end

	// ============================================================
	// execute, memory and writeback
	// ============================================================

	always_comb begin
		alu_a = pick(fwd.e1, rs_val_e);
		rt_fwd_e = pick(fwd.e2, rt_val_e);
		alu_b = ctrl_e.alu_src ? imm_e : rt_fwd_e;
		case (ctrl_e.alu_op)
			mips_pkg::ALU_SUB: alu_y = alu_a - alu_b;
			mips_pkg::ALU_OR: alu_y = alu_a | alu_b;
			default: alu_y = alu_a + alu_b;
		endcase
		st_data = pick(fwd.m, rt_val_m);
	end

	assign dm_addr = alu_m[DA+1:2];
	assign dm_wdata = st_data;
	assign dm_we = ctrl_m.dm_we;

	assign wb_data = (ctrl_w.wb_sel == mips_pkg::WB_MEM) ? mem_w :
		(ctrl_w.wb_sel == mips_pkg::WB_PC8) ? pc8_w : alu_w;
	assign rf_wa = (ctrl_w.wb_sel == mips_pkg::WB_PC8) ? mips_pkg::REG_RA :
		(instr_w[31:26] == mips_pkg::OP_SPECIAL) ? instr_w[15:11] : instr_w[20:16];
	assign rf_we = ctrl_w.rf_we;
	assign rf_wd = wb_data;

	assign retire = '{en: ctrl_w.rf_we, addr: rf_wa, data: wb_data};
	assign store = '{en: ctrl_m.dm_we, addr: alu_m, data: st_data};

	// ============================================================
	// pipeline registers
	// ============================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			instr_d <= '0;
			instr_e <= '0;
			instr_m <= '0;
			instr_w <= '0;
		end else begin
			if (!stall) begin
				pc <= npc;
				instr_d <= imem_data;
			end
			// a stall leaves D in place and sends a nop down to E.
			instr_e <= stall ? '0 : instr_d;
			instr_m <= instr_e;
			instr_w <= instr_m;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			pc8_d <= pc + 32'd8;
		end
		pc8_e <= pc8_d;
		rs_val_e <= d1_val;
		rt_val_e <= d2_val;
		imm_e <= imm_d;
		pc8_m <= pc8_e;
		alu_m <= alu_y;
		rt_val_m <= rt_fwd_e;
		pc8_w <= pc8_m;
		alu_w <= alu_m;
		mem_w <= dm_rdata;
	end

endmodule

`default_nettype wire

// ==== hw/instr_mem.sv ====
`default_nettype none

module instr_mem #(
	parameter int DEPTH = 256
) (
	input  logic                     clk,
	input  logic                     we,
	input  logic [$clog2(DEPTH)-1:0] waddr,
	input  mips_pkg::word_t          wdata,
	input  logic [$clog2(DEPTH)-1:0] raddr,
	output mips_pkg::word_t          rdata
);

	mips_pkg::word_t mem [DEPTH];

	// only the load port writes, fetch reads combinationally.
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	assign rdata = mem[raddr];

endmodule

`default_nettype wire

// ==== hw/data_mem.sv ====
`default_nettype none

module data_mem #(
	parameter int DEPTH = 256
) (
	input  logic                     clk,
	input  logic                     we,
	input  logic [$clog2(DEPTH)-1:0] addr,
	input  mips_pkg::word_t          wdata,
	output mips_pkg::word_t          rdata
);

	mips_pkg::word_t mem [DEPTH];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
	end

	// lw reads in the same cycle it sits in M.
	assign rdata = mem[addr];

endmodule

`default_nettype wire

// ==== hw/mips_core_top.sv ====
`default_nettype none

module mips_core_top #(
	parameter int IMEM_DEPTH = 256,
	parameter int DMEM_DEPTH = 256
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          load_en,
	input  logic [$clog2(IMEM_DEPTH)-1:0] load_addr,
	input  mips_pkg::word_t               load_data,
	output mips_pkg::retire_t             retire,
	output mips_pkg::store_t              store
);

	logic [$clog2(IMEM_DEPTH)-1:0] imem_addr;
	logic [$clog2(DMEM_DEPTH)-1:0] dm_addr;
	mips_pkg::word_t imem_data;
	mips_pkg::word_t instr_d, instr_e, instr_m, instr_w;
	mips_pkg::decode_t dec_d, dec_e, dec_m, dec_w;
	mips_pkg::ctrl_word_t ctrl_d, ctrl_e, ctrl_m, ctrl_w;
	mips_pkg::fwd_t fwd;
	logic stall;
	mips_pkg::reg_addr_t rf_ra1, rf_ra2, rf_wa;
	mips_pkg::word_t rf_rd1, rf_rd2, rf_wd;
	logic rf_we;
	mips_pkg::word_t dm_wdata, dm_rdata;
	logic dm_we;

	instr_mem #(.DEPTH(IMEM_DEPTH)) u_imem (
		.clk(clk), .we(load_en), .waddr(load_addr), .wdata(load_data),
		.raddr(imem_addr), .rdata(imem_data)
	);

	data_mem #(.DEPTH(DMEM_DEPTH)) u_dmem (
		.clk(clk), .we(dm_we), .addr(dm_addr), .wdata(dm_wdata), .rdata(dm_rdata)
	);

	// one classifier per stage.
	instr_decode u_dec_d (.instr(instr_d), .dec(dec_d));
	instr_decode u_dec_e (.instr(instr_e), .dec(dec_e));
	instr_decode u_dec_m (.instr(instr_m), .dec(dec_m));
	instr_decode u_dec_w (.instr(instr_w), .dec(dec_w));

	hazard_control u_ctrl (
		.clk(clk), .rst(rst),
		.dec_d(dec_d), .dec_e(dec_e), .dec_m(dec_m), .dec_w(dec_w),
		.ctrl_d(ctrl_d), .ctrl_e(ctrl_e), .ctrl_m(ctrl_m), .ctrl_w(ctrl_w),
		.fwd(fwd), .stall(stall)
	);

	reg_file u_rf (
		.clk(clk), .rst(rst), .ra1(rf_ra1), .ra2(rf_ra2), .rd1(rf_rd1), .rd2(rf_rd2),
		.we(rf_we), .wa(rf_wa), .wd(rf_wd)
	);

	datapath #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) u_dp (
		.clk(clk), .rst(rst), .imem_addr(imem_addr), .imem_data(imem_data),
		.instr_d(instr_d), .instr_e(instr_e), .instr_m(instr_m), .instr_w(instr_w),
		.ctrl_d(ctrl_d), .ctrl_e(ctrl_e), .ctrl_m(ctrl_m), .ctrl_w(ctrl_w),
		.fwd(fwd), .stall(stall),
		.rf_ra1(rf_ra1), .rf_ra2(rf_ra2), .rf_rd1(rf_rd1), .rf_rd2(rf_rd2),
		.rf_we(rf_we), .rf_wa(rf_wa), .rf_wd(rf_wd),
		.dm_addr(dm_addr), .dm_wdata(dm_wdata), .dm_we(dm_we), .dm_rdata(dm_rdata),
		.retire(retire), .store(store)
	);

endmodule

`default_nettype wire

// ==== dv/tb_isa_model.svh ====
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

// ============================================================
// instruction encoders
// ============================================================

function automatic mips_pkg::word_t addu(input mips_pkg::reg_addr_t rd,
		input mips_pkg::reg_addr_t rs, input mips_pkg::reg_addr_t rt);
	return {6'h00, rs, rt, rd, 5'd0, 6'h21};
endfunction

function automatic mips_pkg::word_t subu(input mips_pkg::reg_addr_t rd,
		input mips_pkg::reg_addr_t rs, input mips_pkg::reg_addr_t rt);
	return {6'h00, rs, rt, rd, 5'd0, 6'h23};
endfunction

function automatic mips_pkg::word_t jr(input mips_pkg::reg_addr_t rs);
	return {6'h00, rs, 15'd0, 6'h08};
endfunction

function automatic mips_pkg::word_t ori(input mips_pkg::reg_addr_t rt,
		input mips_pkg::reg_addr_t rs, input logic [15:0] imm);
	return {6'h0d, rs, rt, imm};
endfunction

function automatic mips_pkg::word_t lui(input mips_pkg::reg_addr_t rt, input logic [15:0] imm);
	return {6'h0f, 5'd0, rt, imm};
endfunction

function automatic mips_pkg::word_t lw(input mips_pkg::reg_addr_t rt, input logic [15:0] off,
		input mips_pkg::reg_addr_t base);
	return {6'h23, base, rt, off};
endfunction

function automatic mips_pkg::word_t sw(input mips_pkg::reg_addr_t rt, input logic [15:0] off,
		input mips_pkg::reg_addr_t base);
	return {6'h2b, base, rt, off};
endfunction

// offset counts words from the delay slot.
function automatic mips_pkg::word_t beq(input mips_pkg::reg_addr_t rs,
		input mips_pkg::reg_addr_t rt, input logic [15:0] off);
	return {6'h04, rs, rt, off};
endfunction

function automatic mips_pkg::word_t j(input logic [25:0] idx);
	return {6'h02, idx};
endfunction

function automatic mips_pkg::word_t jal(input logic [25:0] idx);
	return {6'h03, idx};
endfunction

function automatic mips_pkg::word_t nop();
	return 32'h0000_0000;
endfunction

// ============================================================
// architectural reference
// ============================================================

// runs until pc reaches the closing beq, the last two words of code.
function automatic void run_isa_model(input mips_pkg::word_t code[$]);
	mips_pkg::word_t rf [32];
	mips_pkg::word_t dmem [mips_pkg::word_t];
	mips_pkg::word_t pc;
	mips_pkg::word_t next_pc;
	mips_pkg::word_t target;
	mips_pkg::word_t end_pc;
	mips_pkg::word_t ins;
	mips_pkg::word_t imm_s;
	mips_pkg::word_t addr;
	mips_pkg::word_t wr_val;
	mips_pkg::reg_addr_t rs;
	mips_pkg::reg_addr_t rt;
	mips_pkg::reg_addr_t wr_reg;
	int steps;
	for (int i = 0; i < 32; i++) begin
		rf[i] = '0;
	end
	end_pc = (code.size() - 2) * 4;
	pc = '0;
	next_pc = 32'd4;
	steps = 0;
	while (pc != end_pc && steps < 4096) begin
		ins = code[pc[31:2]];
		rs = ins[25:21];
		rt = ins[20:16];
		imm_s = {{16{ins[15]}}, ins[15:0]};
		addr = rf[rs] + imm_s;
		target = next_pc + 32'd4;
		wr_reg = '0;
		wr_val = '0;
		case (ins[31:26])
			6'h00: begin
				if (ins[5:0] == 6'h21) begin
					wr_reg = ins[15:11];
					wr_val = rf[rs] + rf[rt];
				end else if (ins[5:0] == 6'h23) begin
					wr_reg = ins[15:11];
					wr_val = rf[rs] - rf[rt];
				end else if (ins[5:0] == 6'h08) begin
					target = rf[rs];
				end
			end
			6'h0d: begin
				wr_reg = rt;
				wr_val = rf[rs] | {16'h0000, ins[15:0]};
			end
			6'h0f: begin
				wr_reg = rt;
				wr_val = {ins[15:0], 16'h0000};
			end
			6'h23: begin
				wr_reg = rt;
				wr_val = dmem.exists(addr) ? dmem[addr] : '0;
			end
			6'h2b: begin
				dmem[addr] = rf[rt];
				exp_store.push_back('{en: 1'b1, addr: addr, data: rf[rt]});
			end
			6'h04: begin
				if (rf[rs] == rf[rt]) begin
					target = next_pc + (imm_s << 2);
				end
			end
			6'h02: begin
				target = {next_pc[31:28], ins[25:0], 2'b00};
			end
			6'h03: begin
				target = {next_pc[31:28], ins[25:0], 2'b00};
				wr_reg = 5'd31;
				wr_val = pc + 32'd8;
			end
			default: begin
			end
		endcase
		// register 0 keeps its zero and never shows up as a write.
		if (wr_reg != 5'd0) begin
			rf[wr_reg] = wr_val;
			exp_retire.push_back('{en: 1'b1, addr: wr_reg, data: wr_val});
		end
		pc = next_pc;
		next_pc = target;
		steps++;
	end
endfunction

`endif

// ==== dv/tb_mips_core.sv ====
`default_nettype none

module tb_mips_core;

	localparam int IMEM_DEPTH = 256;
	localparam int DMEM_DEPTH = 256;

	logic clk;
	logic rst;
	logic load_en;
	logic [$clog2(IMEM_DEPTH)-1:0] load_addr;
	mips_pkg::word_t load_data;
	mips_pkg::retire_t retire;
	mips_pkg::store_t store;

	mips_pkg::word_t prog[$];
	mips_pkg::retire_t exp_retire[$];
	mips_pkg::store_t exp_store[$];
	string cur_test = "setup";
	logic active = 1'b0;
	int value_errors = 0;
	int event_errors = 0;
	int checks = 0;
	int cycle_count = 0;
	int start_cycle = 0;
	int cycle_limit = 1000;

	`include "tb_isa_model.svh"

	mips_core_top #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) uut (
		.clk(clk), .rst(rst), .load_en(load_en), .load_addr(load_addr),
		.load_data(load_data), .retire(retire), .store(store)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	// ============================================================
	// checking
	// ============================================================

	task automatic check_value(input string what, input mips_pkg::word_t expected,
			input mips_pkg::word_t actual);
		checks++;
		if (actual !== expected) begin
			value_errors++;
			$display("[ERROR] %s %s: expected %h actual %h", cur_test, what, expected, actual);
		end
	endtask

	task automatic report_counts();
		$display("errors: %0d value mismatches, %0d missing or extra events, %0d values checked",
			value_errors, event_errors, checks);
	endtask

	// outputs come from stage registers, so mid-cycle they are settled.
	always @(negedge clk) begin : monitor
		mips_pkg::retire_t r;
		mips_pkg::store_t s;
		if (active && retire.en) begin
			if (exp_retire.size() == 0) begin
				event_errors++;
				$display("%s: register write to r%0d that the model does not make",
					cur_test, retire.addr);
			end else begin
				r = exp_retire.pop_front();
				check_value("retire addr", {27'b0, r.addr}, {27'b0, retire.addr});
				check_value("retire data", r.data, retire.data);
			end
		end
		if (active && store.en) begin
			if (exp_store.size() == 0) begin
				event_errors++;
				$display("%s: store to %h that the model does not make", cur_test, store.addr);
			end else begin
				s = exp_store.pop_front();
				check_value("store addr", s.addr, store.addr);
				check_value("store data", s.data, store.data);
			end
		end
	end

	initial begin : watchdog
		do begin
			@(posedge clk);
			cycle_count++;
		end while (cycle_count - start_cycle < cycle_limit);
		$display("timeout: %s still waits for %0d register writes and %0d stores after %0d cycles",
			cur_test, exp_retire.size(), exp_store.size(), cycle_limit);
		report_counts();
		$display("test failed");
		$finish;
	end

	// ============================================================
	// program loading and test runs
	// ============================================================

	// reset stays high for the whole load and at least 8 cycles.
	task automatic load_program();
		int n;
		n = (prog.size() > 8) ? prog.size() : 8;
		for (int i = 0; i < n; i++) begin
			@(negedge clk);
			rst = 1'b1;
			load_en = (i < prog.size());
			load_addr = i[$clog2(IMEM_DEPTH)-1:0];
			load_data = (i < prog.size()) ? prog[i] : '0;
		end
		@(negedge clk);
		load_en = 1'b0;
		rst = 1'b0;
	endtask

	task automatic run_test(input string name);
		@(negedge clk);
		cur_test = name;
		prog.push_back(beq(0, 0, 16'hffff));
		prog.push_back(nop());
		exp_retire.delete();
		exp_store.delete();
		run_isa_model(prog);
		start_cycle = cycle_count;
		cycle_limit = 20 * prog.size() + 200;
		load_program();
		@(posedge clk);
		active = 1'b1;
		while (exp_retire.size() != 0 || exp_store.size() != 0) begin
			@(posedge clk);
		end
		// a few more cycles catch writes the model does not make.
		repeat (10) @(posedge clk);
		active = 1'b0;
	endtask

	task automatic test_alu();
		prog.delete();
		prog.push_back(lui(1, 16'h8000));
		prog.push_back(ori(1, 1, 16'hffff));
		prog.push_back(ori(2, 0, 16'hffff));
		prog.push_back(lui(3, 16'hffff));
		prog.push_back(ori(3, 3, 16'hffff));
		prog.push_back(addu(4, 3, 3));
		prog.push_back(subu(5, 0, 3));
		prog.push_back(subu(6, 2, 3));
		prog.push_back(addu(7, 1, 2));
		prog.push_back(addu(0, 1, 2));
		prog.push_back(subu(8, 1, 1));
		prog.push_back(lui(9, 16'h0001));
		run_test("alu");
	endtask

	task automatic test_memory();
		prog.delete();
		prog.push_back(ori(1, 0, 16'h0040));
		prog.push_back(ori(2, 0, 16'h1234));
		prog.push_back(lui(3, 16'hcafe));
		prog.push_back(sw(2, 16'h0000, 1));
		prog.push_back(sw(3, 16'h0004, 1));
		prog.push_back(lw(4, 16'h0000, 1));
		prog.push_back(lw(5, 16'h0004, 1));
		prog.push_back(addu(6, 4, 5));
		prog.push_back(sw(6, 16'hfffc, 1));
		prog.push_back(lw(7, 16'hfffc, 1));
		run_test("memory");
	endtask

	task automatic test_forwarding();
		prog.delete();
		prog.push_back(ori(1, 0, 16'h0005));
		prog.push_back(addu(2, 1, 1));
		prog.push_back(addu(3, 2, 1));
		prog.push_back(subu(4, 3, 2));
		prog.push_back(addu(4, 4, 4));
		prog.push_back(ori(5, 4, 16'h0100));
		prog.push_back(sw(5, 16'h0080, 0));
		prog.push_back(addu(6, 5, 1));
		prog.push_back(sw(6, 16'h0084, 0));
		prog.push_back(ori(7, 0, 16'h0088));
		prog.push_back(sw(6, 16'h0000, 7));
		prog.push_back(addu(8, 1, 2));
		prog.push_back(nop());
		prog.push_back(addu(9, 8, 8));
		run_test("forwarding");
	endtask

	task automatic test_hazards();
		prog.delete();
		prog.push_back(ori(1, 0, 16'h0020));
		prog.push_back(ori(2, 0, 16'h0007));
		prog.push_back(sw(2, 16'h0000, 1));
		prog.push_back(lw(3, 16'h0000, 1));
		prog.push_back(addu(4, 3, 3));
		prog.push_back(lw(5, 16'h0000, 1));
		prog.push_back(beq(5, 2, 16'h0002));
		prog.push_back(ori(6, 0, 16'h0001));
		prog.push_back(ori(6, 0, 16'hdead));
		prog.push_back(ori(8, 0, 16'h0007));
		prog.push_back(beq(8, 2, 16'h0002));
		prog.push_back(addu(9, 8, 8));
		prog.push_back(ori(9, 0, 16'h0bad));
		prog.push_back(lw(10, 16'h0000, 1));
		prog.push_back(sw(10, 16'h0004, 1));
		prog.push_back(lw(11, 16'h0004, 1));
		prog.push_back(lw(12, 16'h0000, 1));
		prog.push_back(nop());
		prog.push_back(beq(12, 0, 16'h0002));
		prog.push_back(ori(13, 0, 16'h0001));
		prog.push_back(ori(14, 0, 16'h0002));
		run_test("hazards");
	endtask

	// word indices are fixed, jump targets depend on them.
	task automatic test_control_flow();
		prog.delete();
		prog.push_back(ori(1, 0, 16'h0001));
		prog.push_back(ori(2, 0, 16'h0002));
		prog.push_back(beq(1, 2, 16'h0005));
		prog.push_back(ori(3, 0, 16'h0003));
		prog.push_back(beq(1, 1, 16'h0002));
		prog.push_back(ori(4, 0, 16'h0004));
		prog.push_back(ori(5, 0, 16'h0005));
		prog.push_back(jal(26'd11));
		prog.push_back(addu(6, 31, 0));
		prog.push_back(j(26'd14));
		prog.push_back(ori(8, 0, 16'h0008));
		prog.push_back(addu(7, 31, 0));
		prog.push_back(jr(31));
		prog.push_back(ori(9, 0, 16'h0009));
		prog.push_back(ori(10, 0, 16'h0044));
		prog.push_back(jr(10));
		prog.push_back(ori(12, 0, 16'h000c));
		prog.push_back(ori(11, 0, 16'h000b));
		run_test("control_flow");
	endtask

	// loads only read the four words the prologue has stored.
	task automatic test_random(input int n);
		int op;
		int r;
		int v;
		mips_pkg::reg_addr_t rd;
		mips_pkg::reg_addr_t rs;
		mips_pkg::reg_addr_t rt;
		logic [15:0] imm;
		logic [15:0] off;
		prog.delete();
		for (int k = 0; k < 4; k++) begin
			off = 16'h0100 + (k[15:0] << 2);
			prog.push_back(sw(0, off, 0));
		end
		for (int k = 0; k < 40; k++) begin
			op = $urandom_range(5);
			r = $urandom_range(7);
			rd = r[4:0];
			r = $urandom_range(7);
			rs = r[4:0];
			r = $urandom_range(7);
			rt = r[4:0];
			v = $urandom();
			imm = v[15:0];
			r = $urandom_range(3);
			off = 16'h0100 + (r[15:0] << 2);
			case (op)
				0: prog.push_back(addu(rd, rs, rt));
				1: prog.push_back(subu(rd, rs, rt));
				2: prog.push_back(ori(rd, rs, imm));
				3: prog.push_back(lui(rd, imm));
				4: prog.push_back(lw(rd, off, 0));
				default: prog.push_back(sw(rt, off, 0));
			endcase
		end
		run_test($sformatf("random_%0d", n));
	endtask

	// ============================================================
	// main sequence
	// ============================================================

	initial begin : main
		void'($urandom(32'hbdbd_44ab));
		rst = 1'b1;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		test_alu();
		test_memory();
		test_forwarding();
		test_hazards();
		test_control_flow();
		for (int n = 0; n < 3; n++) begin
			test_random(n);
		end
		report_counts();
		if (value_errors == 0 && event_errors == 0 && checks > 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+dv
hw/mips_pkg.sv
hw/instr_decode.sv
hw/hazard_control.sv
hw/reg_file.sv
hw/datapath.sv
hw/instr_mem.sv
hw/data_mem.sv
hw/mips_core_top.sv
dv/tb_mips_core.sv

// ==== Bender.yml ====
package:
  name: mips_core

sources:
  - files:
      - hw/mips_pkg.sv
      - hw/instr_decode.sv
      - hw/hazard_control.sv
      - hw/reg_file.sv
      - hw/datapath.sv
      - hw/instr_mem.sv
      - hw/data_mem.sv
      - hw/mips_core_top.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_mips_core.sv
